// File: Bender.yml
package:
  name: arcade_shell

sources:
  - files:
      - rtl/arcade_pkg.sv
      - rtl/core_config_regs.sv
      - rtl/coin_pulse.sv
      - rtl/cabinet_inputs.sv
      - rtl/video_timing.sv
      - rtl/video_output.sv
      - rtl/arcade_shell_top.sv

  - target: test
    files:
      - tests/arcade_shell_tb.sv

// File: rtl/arcade_pkg.sv
/*
 * Arcade shell shared definitions
 * Game and board ids, settings word layout, cabinet input bundles,
 * colour formats, bridge addresses and video timing constants.
 */

`default_nettype none

package arcade_pkg;

    ////////////////////
    // configuration

    typedef enum logic [2:0] {
        game_druaga   = 3'd1,
        game_mappy    = 3'd2,
        game_digdug2  = 3'd3,
        game_motos    = 3'd4,
        game_superpac = 3'd5,
        game_grobda   = 3'd6
    } game_id_t;

    typedef enum logic [2:0] {
        board_druaga   = 3'd0,
        board_superpac = 3'd5,
        board_grobda   = 3'd6
    } board_model_t;

    // host-written settings word with the low bits listed last
    typedef struct packed {
        logic [16:0] unused;
        logic        cabinet;
        logic [2:0]  extend;
        logic        advance;
        logic [2:0]  difficulty;
        logic        service;
        logic        coin_b_hi;
        logic        demo;
        logic [1:0]  coin_a;
        logic [1:0]  life;
    } game_settings_t;

    typedef struct packed {
        logic [7:0] dsw2;
        logic [7:0] dsw1;
        logic [7:0] dsw0;
    } dip_switches_t;

    ////////////////////
    // inputs

    // controller key bitmap with dpad up in bit 0
    typedef struct packed {
        logic start;
        logic select;
        logic r3;
        logic l3;
        logic r2;
        logic l2;
        logic r1;
        logic l1;
        logic face_y;
        logic face_x;
        logic face_b;
        logic face_a;
        logic right;
        logic left;
        logic down;
        logic up;
    } cont_key_t;

    typedef struct packed {
        logic fire;
        logic left;
        logic down;
        logic right;
        logic up;
    } player_input_t;

    typedef struct packed {
        logic coin;
        logic start_2;
        logic start_1;
    } system_input_t;

    ////////////////////
    // video

    typedef struct packed {
        logic [3:0] b;
        logic [3:0] g;
        logic [3:0] r;
    } rgb444_t;

    typedef struct packed {
        logic [7:0] r;
        logic [7:0] g;
        logic [7:0] b;
    } rgb888_t;

    localparam logic [31:0] cfg_game_id_addr  = 32'h8000_0000;
    localparam logic [31:0] cfg_settings_addr = 32'h9000_0000;

    // horizontal events counted in pixels
    localparam logic [8:0] h_active_start = 9'd1;
    localparam logic [8:0] h_active_end   = 9'd290;
    localparam logic [8:0] h_sync_start   = 9'd311;
    localparam logic [8:0] h_sync_end     = 9'd342;
    localparam logic [8:0] h_jump         = 9'd471;

    // vertical events taken at line end
    localparam logic [8:0] v_blank_start = 9'd223;
    localparam logic [8:0] v_sync_start  = 9'd234;
    localparam logic [8:0] v_sync_end    = 9'd241;
    localparam logic [8:0] v_jump        = 9'd492;

    localparam logic [8:0] counter_last = 9'd511;

endpackage

`default_nettype wire

// File: rtl/arcade_shell_top.sv
/*
 * Arcade cabinet shell top level
 * Configuration registers, cabinet inputs and the video path
 * around an external game core.
 */

`timescale 1ns/1ps
`default_nettype none

module arcade_shell_top #(
    parameter int unsigned coin_pulse_len = 1048575
) (
    input  wire                            clk_74a,
    input  wire                            pll_core_locked,
    input  wire                            bridge_wr,
    input  wire  [31:0]                    bridge_addr,
    input  wire  [31:0]                    bridge_wr_data,
    input  wire                            dataslot_requestwrite,
    input  wire                            dataslot_allcomplete,
    input  arcade_pkg::cont_key_t          cont1_key,
    input  arcade_pkg::cont_key_t          cont2_key,
    input  arcade_pkg::rgb444_t            pixel_rgb,
    output logic [8:0]                     hpos,
    output logic [8:0]                     vpos,
    output arcade_pkg::board_model_t       board_model,
    output logic                           core_reset,
    output arcade_pkg::dip_switches_t      dip,
    output arcade_pkg::player_input_t      p1_input,
    output arcade_pkg::player_input_t      p2_input,
    output arcade_pkg::system_input_t      sys_input,
    output arcade_pkg::rgb888_t            video_rgb,
    output logic                           video_de,
    output logic                           video_hs,
    output logic                           video_vs
);

    arcade_pkg::game_settings_t settings;
    arcade_pkg::rgb444_t        gated_rgb;
    logic                       hblank;
    logic                       vblank;
    logic                       hsync;
    logic                       vsync;

    ////////////////////
    // configuration

    core_config_regs i_core_config_regs (
        .clk_74a               (clk_74a),
        .pll_core_locked       (pll_core_locked),
        .bridge_wr             (bridge_wr),
        .bridge_addr           (bridge_addr),
        .bridge_wr_data        (bridge_wr_data),
        .dataslot_requestwrite (dataslot_requestwrite),
        .dataslot_allcomplete  (dataslot_allcomplete),
        .settings              (settings),
        .board_model           (board_model),
        .core_reset            (core_reset)
    );

    ////////////////////
    // controls

    cabinet_inputs #(
        .coin_pulse_len  (coin_pulse_len)
    ) i_cabinet_inputs (
        .clk_74a         (clk_74a),
        .pll_core_locked (pll_core_locked),
        .cont1_key       (cont1_key),
        .cont2_key       (cont2_key),
        .settings        (settings),
        .p1_input        (p1_input),
        .p2_input        (p2_input),
        .sys_input       (sys_input),
        .dip             (dip)
    );

    ////////////////////
    // video

    video_timing i_video_timing (
        .clk_74a         (clk_74a),
        .pll_core_locked (pll_core_locked),
        .pixel_rgb       (pixel_rgb),
        .hpos            (hpos),
        .vpos            (vpos),
        .gated_rgb       (gated_rgb),
        .hblank          (hblank),
        .vblank          (vblank),
        .hsync           (hsync),
        .vsync           (vsync)
    );

    video_output i_video_output (
        .clk_74a         (clk_74a),
        .pll_core_locked (pll_core_locked),
        .gated_rgb       (gated_rgb),
        .hblank          (hblank),
        .vblank          (vblank),
        .hsync           (hsync),
        .vsync           (vsync),
        .video_rgb       (video_rgb),
        .video_de        (video_de),
        .video_hs        (video_hs),
        .video_vs        (video_vs)
    );

endmodule

`default_nettype wire

// File: rtl/cabinet_inputs.sv
/*
 * Cabinet input mapping
 * Routes both controllers onto player and system inputs, stretches
 * the coin buttons and packs the settings word into DIP switches.
 */

`timescale 1ns/1ps
`default_nettype none

module cabinet_inputs #(
    parameter int unsigned coin_pulse_len = 1048575
) (
    input  wire                            clk_74a,
    input  wire                            pll_core_locked,
    input  arcade_pkg::cont_key_t          cont1_key,
    input  arcade_pkg::cont_key_t          cont2_key,
    input  arcade_pkg::game_settings_t     settings,
    output arcade_pkg::player_input_t      p1_input,
    output arcade_pkg::player_input_t      p2_input,
    output arcade_pkg::system_input_t      sys_input,
    output arcade_pkg::dip_switches_t      dip
);

    logic coin1_pulse;
    logic coin2_pulse;

    ////////////////////
    // coin buttons

    // select acts as the coin slot on each pad
    coin_pulse #(
        .pulse_len       (coin_pulse_len)
    ) i_coin1 (
        .clk_74a         (clk_74a),
        .pll_core_locked (pll_core_locked),
        .button          (cont1_key.select),
        .pulse           (coin1_pulse)
    );

    coin_pulse #(
        .pulse_len       (coin_pulse_len)
    ) i_coin2 (
        .clk_74a         (clk_74a),
        .pll_core_locked (pll_core_locked),
        .button          (cont2_key.select),
        .pulse           (coin2_pulse)
    );

    ////////////////////
    // player and system

    assign p1_input = '{fire:  cont1_key.face_a,
                        left:  cont1_key.left,
                        down:  cont1_key.down,
                        right: cont1_key.right,
                        up:    cont1_key.up};

    assign p2_input = '{fire:  cont2_key.face_a,
                        left:  cont2_key.left,
                        down:  cont2_key.down,
                        right: cont2_key.right,
                        up:    cont2_key.up};

    assign sys_input = '{coin:    coin1_pulse | coin2_pulse,
                         start_2: cont2_key.start,
                         start_1: cont1_key.start};

    ////////////////////
    // dip switches

    // coin_b shares its low bit with demo
    assign dip.dsw0 = {settings.life, settings.coin_a, settings.demo, 1'b0,
                       settings.coin_b_hi, settings.demo};
    assign dip.dsw1 = {settings.service, settings.difficulty, settings.advance,
                       settings.extend};
    // switch bank 2 is active low on the board
    assign dip.dsw2 = {6'b00_0000, ~settings.service, ~settings.cabinet};

endmodule

`default_nettype wire

// File: rtl/coin_pulse.sv
/*
 * Coin pulse stretcher
 * A button release loads a down-counter; the pulse stays high
 * for pulse_len cycles while it runs down.
 */

`timescale 1ns/1ps
`default_nettype none

module coin_pulse #(
    parameter int unsigned pulse_len = 1048575
) (
    input  wire  clk_74a,
    input  wire  pll_core_locked,
    input  wire  button,
    output logic pulse
);

    localparam int unsigned cnt_w = $clog2(pulse_len + 1);

    logic             button_q;
    logic [cnt_w-1:0] pulse_cnt;

    always_ff @(posedge clk_74a or negedge pll_core_locked) begin
        if (!pll_core_locked) begin
            button_q  <= 1'b0;
            pulse_cnt <= '0;
        end else begin
            // keep tracking the button so a stale level never fakes a release
            button_q <= button;
            if (pulse_cnt != '0) begin
                pulse_cnt <= pulse_cnt - cnt_w'(1);
            end else if (button_q && !button) begin
                pulse_cnt <= cnt_w'(pulse_len);
            end
        end
    end

    assign pulse = (pulse_cnt != '0);

endmodule

`default_nettype wire

// File: rtl/core_config_regs.sv
/*
 * Core configuration registers
 * Holds the host-written game id and settings word, decodes the board
 * model and keeps the game core in reset while a ROM download runs.
 */

`timescale 1ns/1ps
`default_nettype none

module core_config_regs (
    input  wire                             clk_74a,
    input  wire                             pll_core_locked,
    input  wire                             bridge_wr,
    input  wire  [31:0]                     bridge_addr,
    input  wire  [31:0]                     bridge_wr_data,
    input  wire                             dataslot_requestwrite,
    input  wire                             dataslot_allcomplete,
    output arcade_pkg::game_settings_t      settings,
    output arcade_pkg::board_model_t        board_model,
    output logic                            core_reset
);

    arcade_pkg::game_id_t game_id;

    ////////////////////
    // bridge writes

    always_ff @(posedge clk_74a or negedge pll_core_locked) begin
        if (!pll_core_locked) begin
            game_id  <= arcade_pkg::game_id_t'(3'd0);
            settings <= '0;
        end else if (bridge_wr) begin
            if (bridge_addr == arcade_pkg::cfg_game_id_addr) begin
                game_id <= arcade_pkg::game_id_t'(bridge_wr_data[2:0]);
            end
            if (bridge_addr == arcade_pkg::cfg_settings_addr) begin
                settings <= arcade_pkg::game_settings_t'(bridge_wr_data);
            end
        end
    end

    // only grobda and super pac-man differ from the druaga board
    always_ff @(posedge clk_74a or negedge pll_core_locked) begin
        if (!pll_core_locked) begin
            board_model <= arcade_pkg::board_druaga;
        end else begin
            case (game_id)
                arcade_pkg::game_grobda:   board_model <= arcade_pkg::board_grobda;
                arcade_pkg::game_superpac: board_model <= arcade_pkg::board_superpac;
                default:                   board_model <= arcade_pkg::board_druaga;
            endcase
        end
    end

    ////////////////////
    // download level

    always_ff @(posedge clk_74a or negedge pll_core_locked) begin
        if (!pll_core_locked) begin
            core_reset <= 1'b0;
        end else if (dataslot_requestwrite) begin
            core_reset <= 1'b1;
        end else if (dataslot_allcomplete) begin
            core_reset <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// File: rtl/video_output.sv
/*
 * Scaler video formatting
 * Expands 4-bit colour to 8 bits with data enable, and turns the
 * sync levels into one-cycle pulses on their rising edges.
 */

`timescale 1ns/1ps
`default_nettype none

module video_output (
    input  wire                      clk_74a,
    input  wire                      pll_core_locked,
    input  arcade_pkg::rgb444_t      gated_rgb,
    input  wire                      hblank,
    input  wire                      vblank,
    input  wire                      hsync,
    input  wire                      vsync,
    output arcade_pkg::rgb888_t      video_rgb,
    output logic                     video_de,
    output logic                     video_hs,
    output logic                     video_vs
);

    logic hsync_q;
    logic vsync_q;

    always_ff @(posedge clk_74a or negedge pll_core_locked) begin
        if (!pll_core_locked) begin
            video_rgb <= '0;
            video_de  <= 1'b0;
            video_hs  <= 1'b0;
            video_vs  <= 1'b0;
            hsync_q   <= 1'b1;
            vsync_q   <= 1'b1;
        end else begin
            if (!(hblank || vblank)) begin
                video_de    <= 1'b1;
                // nibble repeated fills the full byte range
                video_rgb.r <= {2{gated_rgb.r}};
                video_rgb.g <= {2{gated_rgb.g}};
                video_rgb.b <= {2{gated_rgb.b}};
            end else begin
                video_de  <= 1'b0;
                video_rgb <= '0;
            end
            // active-low syncs pulse at their end
            video_hs <= hsync && !hsync_q;
            video_vs <= vsync && !vsync_q;
            hsync_q  <= hsync;
            vsync_q  <= vsync;
        end
    end

endmodule

`default_nettype wire

// File: rtl/video_timing.sv
/*
 * Video timing generator
 * Horizontal and vertical counters with jumps, blank and sync levels,
 * and colour gated to black outside the active area.
 */

`timescale 1ns/1ps
`default_nettype none

module video_timing (
    input  wire                      clk_74a,
    input  wire                      pll_core_locked,
    input  arcade_pkg::rgb444_t      pixel_rgb,
    output logic [8:0]               hpos,
    output logic [8:0]               vpos,
    output arcade_pkg::rgb444_t      gated_rgb,
    output logic                     hblank,
    output logic                     vblank,
    output logic                     hsync,
    output logic                     vsync
);

    // levels in step with the counters
    logic hblank_cur;
    logic vblank_cur;
    logic hsync_cur;
    logic vsync_cur;

    ////////////////////
    // counters

    always_ff @(posedge clk_74a or negedge pll_core_locked) begin
        if (!pll_core_locked) begin
            hpos       <= '0;
            vpos       <= '0;
            hblank_cur <= 1'b1;
            vblank_cur <= 1'b1;
            hsync_cur  <= 1'b1;
            vsync_cur  <= 1'b1;
        end else begin
            case (hpos)
                arcade_pkg::h_active_start: begin
                    hblank_cur <= 1'b0;
                    hpos       <= hpos + 9'd1;
                end
                arcade_pkg::h_active_end: begin
                    hblank_cur <= 1'b1;
                    hpos       <= hpos + 9'd1;
                end
                arcade_pkg::h_sync_start: begin
                    hsync_cur <= 1'b0;
                    hpos      <= hpos + 9'd1;
                end
                arcade_pkg::h_sync_end: begin
                    hsync_cur <= 1'b1;
                    hpos      <= arcade_pkg::h_jump;
                end
                arcade_pkg::counter_last: begin
                    hpos <= '0;
                    // step the vertical count at line end
                    case (vpos)
                        arcade_pkg::v_blank_start: begin
                            vblank_cur <= 1'b1;
                            vpos       <= vpos + 9'd1;
                        end
                        arcade_pkg::v_sync_start: begin
                            vsync_cur <= 1'b0;
                            vpos      <= vpos + 9'd1;
                        end
                        arcade_pkg::v_sync_end: begin
                            vsync_cur <= 1'b1;
                            vpos      <= arcade_pkg::v_jump;
                        end
                        arcade_pkg::counter_last: begin
                            vblank_cur <= 1'b0;
                            vpos       <= '0;
                        end
                        default: vpos <= vpos + 9'd1;
                    endcase
                end
                default: hpos <= hpos + 9'd1;
            endcase
        end
    end

    ////////////////////
    // colour stage

    // blanks and syncs move with the gated colour
    always_ff @(posedge clk_74a or negedge pll_core_locked) begin
        if (!pll_core_locked) begin
            hblank    <= 1'b1;
            vblank    <= 1'b1;
            hsync     <= 1'b1;
            vsync     <= 1'b1;
            gated_rgb <= '0;
        end else begin
            hblank    <= hblank_cur;
            vblank    <= vblank_cur;
            hsync     <= hsync_cur;
            vsync     <= vsync_cur;
            gated_rgb <= (hblank_cur || vblank_cur) ? '0 : pixel_rgb;
        end
    end

endmodule

`default_nettype wire

// File: tests/arcade_shell_tb.sv
/*
 * Arcade shell testbench
 * Configuration, input mapping, coin pulse and video frame checks
 * against the shell top level.
 */

`timescale 1ns/1ps
`default_nettype none

module arcade_shell_tb;

    localparam int frame_cycles = 100608;
    localparam int coin_len     = 16;
    localparam int num_tests    = 6;

    logic        clk_74a;
    logic        pll_core_locked;
    logic        bridge_wr;
    logic [31:0] bridge_addr;
    logic [31:0] bridge_wr_data;
    logic        dataslot_requestwrite;
    logic        dataslot_allcomplete;
    logic [15:0] cont1_key;
    logic [15:0] cont2_key;
    logic [11:0] pixel_rgb;
    logic [8:0]  hpos;
    logic [8:0]  vpos;
    logic [2:0]  board_model;
    logic        core_reset;
    logic [23:0] dip;
    logic [4:0]  p1_input;
    logic [4:0]  p2_input;
    logic [2:0]  sys_input;
    logic [23:0] video_rgb;
    logic        video_de;
    logic        video_hs;
    logic        video_vs;

    string test_names [num_tests];
    int    test_errors [num_tests];

    arcade_shell_top #(
        .coin_pulse_len        (coin_len)
    ) i_arcade_shell_top (
        .clk_74a               (clk_74a),
        .pll_core_locked       (pll_core_locked),
        .bridge_wr             (bridge_wr),
        .bridge_addr           (bridge_addr),
        .bridge_wr_data        (bridge_wr_data),
        .dataslot_requestwrite (dataslot_requestwrite),
        .dataslot_allcomplete  (dataslot_allcomplete),
        .cont1_key             (cont1_key),
        .cont2_key             (cont2_key),
        .pixel_rgb             (pixel_rgb),
        .hpos                  (hpos),
        .vpos                  (vpos),
        .board_model           (board_model),
        .core_reset            (core_reset),
        .dip                   (dip),
        .p1_input              (p1_input),
        .p2_input              (p2_input),
        .sys_input             (sys_input),
        .video_rgb             (video_rgb),
        .video_de              (video_de),
        .video_hs              (video_hs),
        .video_vs              (video_vs)
    );

    initial begin
        clk_74a = 1'b0;
        forever #4 clk_74a = ~clk_74a;
    end

    ////////////////////
    // helpers

    task automatic mismatch(input int t, input string what, input logic [31:0] expected,
                            input logic [31:0] actual);
        test_errors[t]++;
        $display("error %s: %s expected %0h actual %0h", test_names[t], what, expected, actual);
    endtask

    task automatic failure(input int t, input string what);
        test_errors[t]++;
        $display("error %s: %s", test_names[t], what);
    endtask

    task automatic finish_test(input int t);
        if (test_errors[t] == 0) begin
            $display("test %s passed", test_names[t]);
        end else begin
            $display("test %s failed with %0d errors", test_names[t], test_errors[t]);
        end
    endtask

    task automatic bridge_write(input logic [31:0] addr, input logic [31:0] data);
        @(posedge clk_74a);
        bridge_wr      <= 1'b1;
        bridge_addr    <= addr;
        bridge_wr_data <= data;
        @(posedge clk_74a);
        bridge_wr <= 1'b0;
    endtask

    task automatic set_select(input int pad, input logic level);
        if (pad == 1) begin
            cont1_key[14] <= level;
        end else begin
            cont2_key[14] <= level;
        end
    endtask

    // only ids 5 and 6 have their own board
    function automatic logic [2:0] board_for_id(input logic [2:0] id);
        case (id)
            3'd5:    return 3'd5;
            3'd6:    return 3'd6;
            default: return 3'd0;
        endcase
    endfunction

    function automatic logic [23:0] dip_for_settings(input logic [31:0] w);
        logic [7:0] dsw0;
        logic [7:0] dsw1;
        logic [7:0] dsw2;
        dsw0 = {w[1:0], w[3:2], w[4], 1'b0, w[5], w[4]};
        dsw1 = {w[6], w[9:7], w[10], w[13:11]};
        dsw2 = {6'd0, ~w[6], ~w[14]};
        return {dsw2, dsw1, dsw0};
    endfunction

    // fire, left, down, right, up from the key bitmap
    function automatic logic [4:0] player_for_keys(input logic [15:0] k);
        return {k[4], k[2], k[1], k[3], k[0]};
    endfunction

    // counters skip ahead at the jump point and wrap after 511
    function automatic logic [8:0] count_after(input logic [8:0] c,
                                               input logic [8:0] jump_from,
                                               input logic [8:0] jump_to);
        if (c == jump_from) begin
            return jump_to;
        end else if (c == 9'd511) begin
            return 9'd0;
        end
        return c + 9'd1;
    endfunction

    task automatic measure_coin_pulse(input int pad);
        int wait_cycles;
        int high_len;
        int extra;
        @(posedge clk_74a);
        set_select(pad, 1'b1);
        repeat (3) @(posedge clk_74a);
        set_select(pad, 1'b0);
        wait_cycles = 0;
        @(negedge clk_74a);
        while (!sys_input[2] && wait_cycles < 4) begin
            @(negedge clk_74a);
            wait_cycles++;
        end
        assert (wait_cycles <= 2)
            else failure(3, $sformatf("coin pulse of pad %0d did not start after release", pad));
        high_len = 0;
        while (sys_input[2] && high_len < 4 * coin_len) begin
            high_len++;
            @(posedge clk_74a);
            // second press and release while the pulse runs
            if (high_len == 4) set_select(pad, 1'b1);
            if (high_len == 8) set_select(pad, 1'b0);
            @(negedge clk_74a);
        end
        assert (high_len == coin_len) else mismatch(3, "coin pulse length", coin_len, high_len);
        extra = 0;
        repeat (3 * coin_len) begin
            @(negedge clk_74a);
            if (sys_input[2]) extra++;
        end
        assert (extra == 0) else mismatch(3, "cycles of a second coin pulse", 0, extra);
    endtask

    ////////////////////
    // test sequence

    initial begin
        int          cycles;
        int          hs_count;
        int          de_lines;
        int          de_run;
        int          total_errors;
        int          failed_tests;
        logic [31:0] word;
        logic [15:0] k1;
        logic [15:0] k2;
        logic [11:0] pix;
        logic [23:0] exp_rgb;
        logic [8:0]  h_prev;
        logic [8:0]  v_prev;
        logic [8:0]  exp_h;
        logic [8:0]  exp_v;

        test_names[0] = "board_model";
        test_names[1] = "dip_packing";
        test_names[2] = "input_mapping";
        test_names[3] = "coin_pulse";
        test_names[4] = "video_frames";
        test_names[5] = "video_colour";
        for (int t = 0; t < num_tests; t++) test_errors[t] = 0;
        void'($urandom(68050));

        pll_core_locked       = 1'b0;
        bridge_wr             = 1'b0;
        bridge_addr           = '0;
        bridge_wr_data        = '0;
        dataslot_requestwrite = 1'b0;
        dataslot_allcomplete  = 1'b0;
        cont1_key             = '0;
        cont2_key             = '0;
        pixel_rgb             = '0;
        repeat (16) @(posedge clk_74a);
        pll_core_locked <= 1'b1;
        repeat (4) @(posedge clk_74a);

        // game id decode
        @(negedge clk_74a);
        assert (board_model == 3'd0) else mismatch(0, "board after reset", 0, board_model);
        for (int id = 0; id < 8; id++) begin
            bridge_write(arcade_pkg::cfg_game_id_addr, 32'(id));
            @(posedge clk_74a);
            @(negedge clk_74a);
            assert (board_model == board_for_id(3'(id)))
                else mismatch(0, $sformatf("board for id %0d", id), board_for_id(3'(id)),
                              board_model);
        end
        bridge_write(arcade_pkg::cfg_game_id_addr, 32'd6);
        bridge_write(32'h8000_0004, 32'd1);
        bridge_write(arcade_pkg::cfg_settings_addr, 32'd5);
        repeat (2) @(posedge clk_74a);
        @(negedge clk_74a);
        assert (board_model == 3'd6) else mismatch(0, "board after other writes", 6, board_model);
        finish_test(0);

        // settings word into dip switches
        repeat (8) begin
            word = $urandom;
            bridge_write(arcade_pkg::cfg_settings_addr, word);
            @(negedge clk_74a);
            assert (dip == dip_for_settings(word))
                else mismatch(1, "dip switches", dip_for_settings(word), dip);
        end
        bridge_write(32'h9000_0010, ~word);
        @(negedge clk_74a);
        assert (dip == dip_for_settings(word))
            else mismatch(1, "dip after unrelated write", dip_for_settings(word), dip);
        finish_test(1);

        // controllers and download level with select held low
        repeat (8) begin
            k1 = 16'($urandom) & 16'hbfff;
            k2 = 16'($urandom) & 16'hbfff;
            @(posedge clk_74a);
            cont1_key <= k1;
            cont2_key <= k2;
            @(negedge clk_74a);
            assert (p1_input == player_for_keys(k1))
                else mismatch(2, "p1 input", player_for_keys(k1), p1_input);
            assert (p2_input == player_for_keys(k2))
                else mismatch(2, "p2 input", player_for_keys(k2), p2_input);
            assert (sys_input[1:0] == {k2[15], k1[15]})
                else mismatch(2, "start bits", {k2[15], k1[15]}, sys_input[1:0]);
        end
        assert (core_reset == 1'b0) else mismatch(2, "core reset before download", 0, core_reset);
        @(posedge clk_74a);
        dataslot_requestwrite <= 1'b1;
        @(posedge clk_74a);
        dataslot_requestwrite <= 1'b0;
        @(negedge clk_74a);
        assert (core_reset == 1'b1) else mismatch(2, "core reset after request", 1, core_reset);
        repeat (5) @(posedge clk_74a);
        @(negedge clk_74a);
        assert (core_reset == 1'b1) else mismatch(2, "core reset held", 1, core_reset);
        @(posedge clk_74a);
        dataslot_allcomplete <= 1'b1;
        @(posedge clk_74a);
        dataslot_allcomplete <= 1'b0;
        @(negedge clk_74a);
        assert (core_reset == 1'b0) else mismatch(2, "core reset after complete", 0, core_reset);
        @(posedge clk_74a);
        cont1_key <= '0;
        cont2_key <= '0;
        finish_test(2);

        measure_coin_pulse(1);
        measure_coin_pulse(2);
        finish_test(3);

        ////////////////////
        // video frames

        pix = 12'($urandom);
        exp_rgb = {pix[3:0], pix[3:0], pix[7:4], pix[7:4], pix[11:8], pix[11:8]};
        @(posedge clk_74a);
        pixel_rgb <= pix;
        // wait for a frame boundary
        do begin
            @(negedge clk_74a);
        end while (!video_vs);
        h_prev = hpos;
        v_prev = vpos;
        for (int frame = 0; frame < 2; frame++) begin
            cycles   = 0;
            hs_count = 0;
            de_lines = 0;
            de_run   = 0;
            do begin
                @(negedge clk_74a);
                cycles++;
                exp_h = count_after(h_prev, 9'd342, 9'd471);
                exp_v = (h_prev == 9'd511) ? count_after(v_prev, 9'd241, 9'd492) : v_prev;
                assert (hpos == exp_h) else mismatch(4, "hpos step", exp_h, hpos);
                assert (vpos == exp_v) else mismatch(4, "vpos step", exp_v, vpos);
                h_prev = hpos;
                v_prev = vpos;
                if (video_hs) hs_count++;
                if (video_de) begin
                    de_run++;
                    assert (video_rgb == exp_rgb)
                        else mismatch(5, "colour with de", exp_rgb, video_rgb);
                end else begin
                    assert (video_rgb == 24'd0)
                        else mismatch(5, "colour without de", 0, video_rgb);
                    if (de_run != 0) begin
                        assert (de_run == 289) else mismatch(4, "de cycles in line", 289, de_run);
                        de_lines++;
                        de_run = 0;
                    end
                end
            end while (!video_vs);
            assert (cycles == frame_cycles)
                else mismatch(4, "cycles between vs pulses", frame_cycles, cycles);
            assert (hs_count == 262) else mismatch(4, "hs pulses per frame", 262, hs_count);
            assert (de_lines == 224) else mismatch(4, "de lines per frame", 224, de_lines);
        end
        finish_test(4);
        finish_test(5);

        total_errors = 0;
        failed_tests = 0;
        for (int t = 0; t < num_tests; t++) begin
            total_errors += test_errors[t];
            if (test_errors[t] != 0) failed_tests++;
        end
        $display("tests run: %0d, tests failed: %0d, errors: %0d", num_tests, failed_tests,
                 total_errors);
        if (total_errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

    // three frames cover the sync wait and two measured frames
    initial begin
        repeat (3 * frame_cycles + 5000) @(posedge clk_74a);
        $display("watchdog expired before the tests completed");
        $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog.f
rtl/arcade_pkg.sv
rtl/core_config_regs.sv
rtl/coin_pulse.sv
rtl/cabinet_inputs.sv
rtl/video_timing.sv
rtl/video_output.sv
rtl/arcade_shell_top.sv
tests/arcade_shell_tb.sv
